/* include/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// datapath width
`define XLEN 32

// memory depths in 32-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

/* source/rv_isa_pkg.sv */
`include "core_settings.svh"

package rv_isa_pkg;

    // major opcodes handled by this core
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OPIMM  = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_t;

    typedef logic [2:0] funct3_t;   // instr[14:12]

    typedef logic [4:0] regIdx_t;   // rs1/rs2/rd field

    typedef logic [`XLEN-1:0] word_t;

endpackage

/* source/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    // instruction class handed to the alu decode
    typedef enum logic [2:0] {
        AOP_R      = 3'b000,
        AOP_I      = 3'b001,
        AOP_LOAD   = 3'b010,
        AOP_STORE  = 3'b011,
        AOP_BRANCH = 3'b100,
        AOP_JUMP   = 3'b101,   // jal and jalr share this class
        AOP_LUI    = 3'b110,
        AOP_AUIPC  = 3'b111
    } aluOp_t;

    typedef enum logic [1:0] {RES_ALU, RES_LOAD, RES_PC4, RES_PCIMM} resultSrc_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immSrc_t;

    // unsigned forms only matter for loads
    typedef enum logic [2:0] {MEM_W, MEM_H, MEM_B, MEM_BU, MEM_HU} memCtrl_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASSB   // lui just forwards the immediate
    } aluFn_t;

endpackage

/* source/ctrlIf.sv */
`timescale 1ns/1ns

interface ctrlIf;
    import core_ctrl_pkg::*;

    resultSrc_t resultSrc;  // writeback select
    logic       memWrite;
    logic       memRead;
    logic       aluSrc;     // 1 = immediate operand
    immSrc_t    immSrc;
    logic       regWrite;
    aluOp_t     aluOp;
    memCtrl_t   memCtrl;
    logic       jalr;
    logic       jump;
    logic       branch;

    modport decoder (output resultSrc, memWrite, memRead, aluSrc, immSrc, regWrite,
                     aluOp, memCtrl, jalr, jump, branch);

    modport consumer (input resultSrc, memWrite, memRead, aluSrc, immSrc, regWrite,
                      aluOp, memCtrl, jalr, jump, branch);
endinterface

/* source/control.sv */
`timescale 1ns/1ns

module control (
    input  rv_isa_pkg::opcode_t opcode,  // instr[6:0]
    input  rv_isa_pkg::funct3_t funct3,
    ctrlIf.decoder              ctrl
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    always_comb begin
        ctrl.resultSrc = RES_ALU;   // everything inactive unless decoded
        ctrl.memWrite  = 1'b0;
        ctrl.memRead   = 1'b0;
        ctrl.aluSrc    = 1'b0;
        ctrl.immSrc    = IMM_I;
        ctrl.regWrite  = 1'b0;
        ctrl.aluOp     = AOP_R;
        ctrl.memCtrl   = MEM_W;
        ctrl.jalr      = 1'b0;
        ctrl.jump      = 1'b0;
        ctrl.branch    = 1'b0;

        case (opcode)
            OPC_OP: begin
                ctrl.aluOp    = AOP_R;
                ctrl.regWrite = 1'b1;
            end
            OPC_OPIMM: begin
                ctrl.aluOp    = AOP_I;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.aluOp     = AOP_LOAD;
                ctrl.aluSrc    = 1'b1;    // base + offset
                ctrl.resultSrc = RES_LOAD;
                ctrl.memRead   = 1'b1;
                case (funct3)
                    3'b000: ctrl.memCtrl = MEM_B;   // lb
                    3'b001: ctrl.memCtrl = MEM_H;   // lh
                    3'b010: ctrl.memCtrl = MEM_W;   // lw
                    3'b100: ctrl.memCtrl = MEM_BU;  // lbu
                    3'b101: ctrl.memCtrl = MEM_HU;  // lhu
                    default: ctrl.memRead = 1'b0;
                endcase
                ctrl.regWrite = ctrl.memRead;     // illegal width writes nothing
            end
            OPC_STORE: begin
                ctrl.aluOp    = AOP_STORE;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = IMM_S;
                ctrl.memWrite = 1'b1;
                case (funct3)
                    3'b000: ctrl.memCtrl = MEM_B;   // sb
                    3'b001: ctrl.memCtrl = MEM_H;   // sh
                    3'b010: ctrl.memCtrl = MEM_W;   // sw
                    default: ctrl.memWrite = 1'b0;
                endcase
            end
            OPC_BRANCH: begin
                ctrl.aluOp  = AOP_BRANCH;   // compares rs1 against rs2
                ctrl.immSrc = IMM_B;
                ctrl.branch = 1'b1;
            end
            OPC_JAL: begin
                ctrl.aluOp     = AOP_JUMP;
                ctrl.aluSrc    = 1'b1;
                ctrl.immSrc    = IMM_J;
                ctrl.resultSrc = RES_PC4;   // link value
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
            end
            OPC_JALR: begin
                ctrl.aluOp     = AOP_JUMP;
                ctrl.aluSrc    = 1'b1;
                ctrl.immSrc    = IMM_I;
                ctrl.resultSrc = RES_PC4;
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jalr      = 1'b1;
            end
            OPC_LUI: begin
                ctrl.aluOp    = AOP_LUI;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = IMM_U;
                ctrl.regWrite = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.aluOp     = AOP_AUIPC;
                ctrl.aluSrc    = 1'b1;
                ctrl.immSrc    = IMM_U;
                ctrl.resultSrc = RES_PCIMM;
                ctrl.regWrite  = 1'b1;
            end
            default: begin
                ctrl.regWrite = 1'b0;   // bubble or unsupported opcode
            end
        endcase
    end

endmodule

/* source/immExtend.sv */
`timescale 1ns/1ns

module immExtend (
    input  rv_isa_pkg::word_t instr,
    ctrlIf.consumer           ctrl,
    output rv_isa_pkg::word_t imm
);
    import core_ctrl_pkg::*;

    always_comb begin
        case (ctrl.immSrc)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // branch offset with bit 0 always zero
            IMM_B: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                          instr[11:8], 1'b0};
            IMM_U: imm = {instr[31:12], 12'b0};   // lui / auipc
            IMM_J: imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                          instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

/* source/regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic                clk,
    input  logic                rst,
    input  rv_isa_pkg::regIdx_t ra1,
    input  rv_isa_pkg::regIdx_t ra2,
    output rv_isa_pkg::word_t   rd1,
    output rv_isa_pkg::word_t   rd2,
    input  logic                we,
    input  rv_isa_pkg::regIdx_t wa,
    input  rv_isa_pkg::word_t   wd
);
    import rv_isa_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;     // x0 is never written
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];  // async read
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* source/executeUnit.sv */
`timescale 1ns/1ns

module executeUnit (
    ctrlIf.consumer           ctrl,
    input  rv_isa_pkg::funct3_t funct3,
    input  logic              funct7b5,
    input  rv_isa_pkg::word_t pc,
    input  rv_isa_pkg::word_t rs1,
    input  rv_isa_pkg::word_t rs2,
    input  rv_isa_pkg::word_t imm,
    output rv_isa_pkg::word_t aluResult,
    output logic              redirect,
    output rv_isa_pkg::word_t target
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    aluFn_t aluFn;
    word_t  srcB;
    word_t  jalrSum;
    logic   taken;

    assign srcB = ctrl.aluSrc ? imm : rs2;

    // alu decode
    always_comb begin
        case (ctrl.aluOp)
            AOP_R, AOP_I: begin
                case (funct3)
                    3'b000: aluFn = (ctrl.aluOp == AOP_R && funct7b5) ? ALU_SUB : ALU_ADD;
                    3'b001: aluFn = ALU_SLL;
                    3'b010: aluFn = ALU_SLT;
                    3'b011: aluFn = ALU_SLTU;
                    3'b100: aluFn = ALU_XOR;
                    3'b101: aluFn = funct7b5 ? ALU_SRA : ALU_SRL;  // srai keeps bit 30 too
                    3'b110: aluFn = ALU_OR;
                    default: aluFn = ALU_AND;
                endcase
            end
            AOP_BRANCH: aluFn = ALU_SUB;
            AOP_LUI:    aluFn = ALU_PASSB;
            default:    aluFn = ALU_ADD;     // address calc for loads/stores
        endcase
    end

    always_comb begin
        case (aluFn)
            ALU_ADD:  aluResult = rs1 + srcB;
            ALU_SUB:  aluResult = rs1 - srcB;
            ALU_SLL:  aluResult = rs1 << srcB[4:0];
            ALU_SLT:  aluResult = word_t'($signed(rs1) < $signed(srcB));
            ALU_SLTU: aluResult = word_t'(rs1 < srcB);
            ALU_XOR:  aluResult = rs1 ^ srcB;
            ALU_SRL:  aluResult = rs1 >> srcB[4:0];
            ALU_SRA:  aluResult = word_t'($signed(rs1) >>> srcB[4:0]);
            ALU_OR:   aluResult = rs1 | srcB;
            ALU_AND:  aluResult = rs1 & srcB;
            default:  aluResult = srcB;
        endcase
    end

    // branch compare always on the two registers
    always_comb begin
        case (funct3)
            3'b000:  taken = (rs1 == rs2);                    // beq
            3'b001:  taken = (rs1 != rs2);                    // bne
            3'b100:  taken = ($signed(rs1) < $signed(rs2));   // blt
            3'b101:  taken = ($signed(rs1) >= $signed(rs2));  // bge
            3'b110:  taken = (rs1 < rs2);                     // bltu
            3'b111:  taken = (rs1 >= rs2);                    // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign jalrSum  = rs1 + imm;
    assign redirect = ctrl.jump || (ctrl.branch && taken);
    assign target   = ctrl.jalr ? {jalrSum[$bits(word_t)-1:1], 1'b0} : pc + imm;

endmodule

/* source/loadStoreUnit.sv */
`timescale 1ns/1ns
`include "core_settings.svh"

module loadStoreUnit (
    input  logic              clk,
    ctrlIf.consumer           ctrl,
    input  rv_isa_pkg::word_t addr,
    input  rv_isa_pkg::word_t storeData,
    output rv_isa_pkg::word_t loadData
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int DmemAw = $clog2(`DMEM_WORDS);

    word_t             dmem [`DMEM_WORDS];
    logic [DmemAw-1:0] wordIdx;
    logic [3:0]        laneEn;
    word_t             laneData;
    word_t             rdWord;
    logic [7:0]        rdByte;
    logic [15:0]       rdHalf;

    assign wordIdx = addr[DmemAw+1:2];
    assign rdWord  = dmem[wordIdx];
    assign rdByte  = rdWord[{addr[1:0], 3'b000} +: 8];
    assign rdHalf  = addr[1] ? rdWord[31:16] : rdWord[15:0];

    // store lanes and replicated data
    always_comb begin
        case (ctrl.memCtrl)
            MEM_B, MEM_BU: begin
                laneEn   = 4'b0001 << addr[1:0];
                laneData = {4{storeData[7:0]}};
            end
            MEM_H, MEM_HU: begin
                laneEn   = addr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{storeData[15:0]}};
            end
            default: begin
                laneEn   = 4'b1111;
                laneData = storeData;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.memWrite) begin
            for (int i = 0; i < 4; i++) begin
                if (laneEn[i]) begin
                    dmem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        case (ctrl.memCtrl)
            MEM_B:   loadData = {{24{rdByte[7]}}, rdByte};
            MEM_BU:  loadData = {24'b0, rdByte};
            MEM_H:   loadData = {{16{rdHalf[15]}}, rdHalf};
            MEM_HU:  loadData = {16'b0, rdHalf};
            default: loadData = rdWord;
        endcase
        if (!ctrl.memRead) begin
            loadData = '0;   // quiet when no load is decoded
        end
    end

endmodule

/* source/cpuTop.sv */
`timescale 1ns/1ns
`include "core_settings.svh"

module cpuTop (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           progWe,
    input  logic [$clog2(`IMEM_WORDS)-1:0] progAddr,   // word index
    input  rv_isa_pkg::word_t              progData,
    output logic                           wbEn,
    output rv_isa_pkg::regIdx_t            wbAddr,
    output rv_isa_pkg::word_t              wbData
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int ImemAw = $clog2(`IMEM_WORDS);

    word_t   imem [`IMEM_WORDS];
    word_t   pcF;
    word_t   pcD;
    word_t   instrD;
    logic    validD;     // cleared when the fetch is squashed
    word_t   instrX;
    opcode_t opcodeX;
    word_t   imm;
    word_t   rs1;
    word_t   rs2;
    word_t   aluResult;
    word_t   target;
    word_t   loadData;
    logic    redirect;

    ctrlIf ctrlBus();

    always_ff @(posedge clk) begin
        if (rst && progWe) begin
            imem[progAddr] <= progData;   // program load only during reset
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcF    <= `RESET_PC;
            validD <= 1'b0;
        end else begin
            pcF    <= redirect ? target : pcF + 32'd4;
            validD <= !redirect;
        end
    end

    // F/D payload
    always_ff @(posedge clk) begin
        instrD <= imem[pcF[ImemAw+1:2]];
        pcD    <= pcF;
    end

    assign instrX  = validD ? instrD : '0;   // all-zero word decodes to nothing
    assign opcodeX = opcode_t'(instrX[6:0]);

    control controlInst (.opcode(opcodeX), .funct3(instrX[14:12]), .ctrl(ctrlBus.decoder));

    immExtend immInst (.instr(instrX), .ctrl(ctrlBus.consumer), .imm(imm));

    regFile regInst (
        .clk(clk), .rst(rst),
        .ra1(instrX[19:15]), .ra2(instrX[24:20]), .rd1(rs1), .rd2(rs2),
        .we(wbEn), .wa(wbAddr), .wd(wbData)
    );

    executeUnit exInst (
        .ctrl(ctrlBus.consumer), .funct3(instrX[14:12]), .funct7b5(instrX[30]),
        .pc(pcD), .rs1(rs1), .rs2(rs2), .imm(imm),
        .aluResult(aluResult), .redirect(redirect), .target(target)
    );

    loadStoreUnit lsuInst (
        .clk(clk), .ctrl(ctrlBus.consumer),
        .addr(aluResult), .storeData(rs2), .loadData(loadData)
    );

    assign wbAddr = instrX[11:7];
    assign wbEn   = ctrlBus.regWrite && (wbAddr != '0);

    always_comb begin
        case (ctrlBus.resultSrc)
            RES_LOAD:  wbData = loadData;
            RES_PC4:   wbData = pcD + 32'd4;   // link address
            RES_PCIMM: wbData = target;        // auipc target is pc+imm here
            default:   wbData = aluResult;
        endcase
    end

endmodule

/* testbench/tb_cpuTop.sv */
`timescale 1ns/1ns
`include "core_settings.svh"

module tb_cpuTop;
    import rv_isa_pkg::*;

    localparam int ProgLen    = 200;
    localparam int DataBytes  = 32;    // region filled by the preamble stores
    localparam int WaitCycles = 64;
    localparam int TailCycles = 40;

    logic                           clk = 1'b0;
    logic                           rst;
    logic                           progWe;
    logic [$clog2(`IMEM_WORDS)-1:0] progAddr;
    word_t                          progData;
    logic                           wbEn;
    regIdx_t                        wbAddr;
    word_t                          wbData;

    logic [31:0] lcgState = 32'h7d9429b8;
    word_t       prog [ProgLen];
    word_t       immOf [ProgLen];      // intended immediate of each slot
    logic        landed [ProgLen];     // slot is a branch or jump target
    word_t       xr [32];
    logic [7:0]  mem [DataBytes + 4];
    regIdx_t     expAddr [$];
    word_t       expData [$];
    int          expCls [$];           // 0 alu/upper, 1 load, 2 link
    int          chk [3];
    int          err [3];
    int          errors = 0;
    int          testsFailed = 0;

    cpuTop dut_i (
        .clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int unsigned randBelow(int unsigned n);
        logic [31:0] r;
        r = nextRand();
        return (r >> 8) % n;   // low bits of an LCG repeat too soon
    endfunction

    function automatic word_t encI(word_t imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic word_t encS(word_t imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic word_t encB(word_t imm, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t encJ(word_t imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // signed compare built from the sign bits
    function automatic logic lessSigned(word_t a, word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic word_t aluCalc(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, lessSigned(a, b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return (a >> b[4:0]) | ({32{alt & a[31]}} & ~(32'hffff_ffff >> b[4:0]));
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return lessSigned(a, b);
            3'd5: return !lessSigned(a, b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic put(int slot, word_t w, word_t imm);
        prog[slot]  = w;
        immOf[slot] = imm;
    endtask

    task automatic genProgram();
        int         i;
        int         t;
        logic [2:0] f3;
        logic       alt;
        word_t      imm;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        foreach (landed[s]) begin
            landed[s] = 1'b0;
        end
        for (int k = 0; k < DataBytes / 4; k++) begin   // preamble gives every data word a value
            imm = nextRand() & 32'hffff_f000;
            put(3 * k, {imm[31:12], 5'd1, 7'h37}, imm);
            imm = 32'(randBelow(4096)) - 32'd2048;
            put(3 * k + 1, encI(imm, 5'd1, 3'd0, 5'd1, 7'h13), imm);
            put(3 * k + 2, encS(32'(4 * k), 5'd1, 5'd0, 3'd2), 32'(4 * k));
        end
        i = 3 * DataBytes / 4;
        while (i < ProgLen - 1) begin
            rd  = 5'(randBelow(31));   // x31 is kept for jalr bases
            rs1 = 5'(randBelow(32));
            rs2 = 5'(randBelow(32));
            f3  = 3'(randBelow(8));
            alt = randBelow(2) == 1;
            t   = i + 1 + int'(randBelow(4));
            if (t > ProgLen - 1) t = ProgLen - 1;
            case (randBelow(10))
                0, 1, 2: put(i, {(alt && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00,
                                 rs2, rs1, f3, rd, 7'h33}, '0);
                3, 4: begin
                    imm = 32'(randBelow(4096)) - 32'd2048;
                    if (f3 == 3'd1) imm = {27'b0, imm[4:0]};
                    if (f3 == 3'd5) imm = {21'b0, alt, 5'b0, imm[4:0]};   // srai sets bit 30
                    put(i, encI(imm, rs1, f3, rd, 7'h13), imm);
                end
                5: begin
                    imm = nextRand() & 32'hffff_f000;
                    put(i, {imm[31:12], rd, alt ? 7'h17 : 7'h37}, imm);
                end
                6: begin
                    f3 = 3'(randBelow(5));
                    if (f3 >= 3'd3) f3 = f3 + 3'd1;   // skip the unused code 3
                    imm = 32'(randBelow(DataBytes >> f3[1:0]) << f3[1:0]);
                    put(i, encI(imm, 5'd0, f3, rd, 7'h03), imm);
                end
                7: begin
                    f3  = 3'(randBelow(3));
                    imm = 32'(randBelow(DataBytes >> f3[1:0]) << f3[1:0]);
                    put(i, encS(imm, rs2, 5'd0, f3), imm);
                end
                8: begin
                    f3 = 3'(randBelow(6));
                    if (f3 >= 3'd2) f3 = f3 + 3'd2;
                    landed[t] = 1'b1;
                    put(i, encB(32'(4 * (t - i)), rs2, rs1, f3), 32'(4 * (t - i)));
                end
                default: begin
                    if (i + 1 < ProgLen - 1 && !landed[i + 1]) begin
                        t = (t + 1 > ProgLen - 1) ? ProgLen - 1 : t + 1;
                        put(i, encI(32'(4 * t), 5'd0, 3'd0, 5'd31, 7'h13), 32'(4 * t));
                        imm = 32'(randBelow(2));   // odd offset checks bit 0 clearing
                        put(i + 1, encI(imm, 5'd31, 3'd0, rd, 7'h67), imm);
                        i++;
                    end else begin
                        put(i, encJ(32'(4 * (t - i)), rd), 32'(4 * (t - i)));
                    end
                    landed[t] = 1'b1;
                end
            endcase
            i++;
        end
        put(ProgLen - 1, encJ('0, 5'd0), '0);   // park on jal-to-self
    endtask

    task automatic runModel();
        word_t pc;
        word_t w;
        word_t imm;
        word_t a;
        word_t b;
        word_t val;
        word_t npc;
        word_t addr;
        logic  wr;
        int    cls;
        int    steps;
        pc    = '0;
        steps = 0;
        foreach (xr[r]) begin
            xr[r] = '0;
        end
        while (pc != 4 * (ProgLen - 1) && steps < 4 * ProgLen) begin
            w   = prog[pc >> 2];
            imm = immOf[pc >> 2];
            a   = xr[w[19:15]];
            b   = xr[w[24:20]];
            npc = pc + 4;
            wr  = 1'b1;
            cls = 0;
            val = '0;
            case (w[6:0])
                7'h33: val = aluCalc(w[14:12], w[30], a, b);
                7'h13: val = aluCalc(w[14:12], w[30] && w[14:12] == 3'd5, a, imm);
                7'h37: val = imm;
                7'h17: val = pc + imm;
                7'h03: begin
                    addr = a + imm;
                    val  = {mem[addr + 3], mem[addr + 2], mem[addr + 1], mem[addr]};
                    case (w[14:12])
                        3'd0: val = {{24{val[7]}}, val[7:0]};
                        3'd1: val = {{16{val[15]}}, val[15:0]};
                        3'd4: val = {24'b0, val[7:0]};
                        3'd5: val = {16'b0, val[15:0]};
                        default: val = val;
                    endcase
                    cls = 1;
                end
                7'h23: begin
                    addr = a + imm;
                    wr   = 1'b0;
                    mem[addr] = b[7:0];
                    if (w[14:12] != 3'd0) mem[addr + 1] = b[15:8];
                    if (w[14:12] == 3'd2) begin
                        mem[addr + 2] = b[23:16];
                        mem[addr + 3] = b[31:24];
                    end
                end
                7'h63: begin
                    wr = 1'b0;
                    if (branchTaken(w[14:12], a, b)) npc = pc + imm;
                end
                7'h6f: begin
                    val = pc + 4;
                    npc = pc + imm;
                    cls = 2;
                end
                default: begin   // jalr
                    val = pc + 4;
                    npc = (a + imm) & ~32'd1;
                    cls = 2;
                end
            endcase
            if (wr && w[11:7] != 5'd0) begin
                xr[w[11:7]] = val;
                expAddr.push_back(w[11:7]);
                expData.push_back(val);
                expCls.push_back(cls);
            end
            pc = npc;
            steps++;
        end
        if (pc != 4 * (ProgLen - 1)) begin
            $display("model did not reach the end loop");
            errors++;
        end
    endtask

    task automatic checkWrite(int idx);
        int c;
        c = expCls[idx];
        chk[c]++;
        if (wbAddr !== expAddr[idx]) begin
            $display("Fail: wbAddr write %0d expected %h got %h", idx, expAddr[idx], wbAddr);
            err[c]++;
        end
        if (wbData !== expData[idx]) begin
            $display("Fail: wbData write %0d expected %h got %h", idx, expData[idx], wbData);
            err[c]++;
        end
    endtask

    task automatic reportTest(string name, int nChk, int nErr);
        $display("test %s: %0d checks, %0d errors", name, nChk, nErr);
        errors += nErr;
        if (nErr != 0) testsFailed++;
    endtask

    initial begin
        int   got;
        int   cycles;
        int   extra;
        int   rstErr;
        logic timedOut;
        rst      = 1'b1;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        rstErr   = 0;
        genProgram();
        runModel();
        for (int k = 0; k < ProgLen + 6; k++) begin   // program load and five idle reset cycles
            @(negedge clk);
            if (k > 0 && wbEn !== 1'b0) begin
                $display("Fail: wbEn during reset cycle %0d expected 0 got %h", k, wbEn);
                rstErr++;
            end
            progWe   = k < ProgLen;
            progAddr = k[$bits(progAddr)-1:0];
            progData = (k < ProgLen) ? prog[k % ProgLen] : '0;
        end
        rst = 1'b0;
        reportTest("reset quiet", ProgLen + 5, rstErr);
        got      = 0;
        timedOut = 1'b0;
        while (got < expData.size() && !timedOut) begin
            cycles = 0;
            @(negedge clk);   // outputs settle mid-cycle
            while (wbEn !== 1'b1 && cycles < WaitCycles) begin
                @(negedge clk);
                cycles++;
            end
            if (wbEn !== 1'b1) begin
                $display("timeout waiting for write %0d of %0d", got, expData.size());
                timedOut = 1'b1;
            end else begin
                checkWrite(got);
                got++;
            end
        end
        extra = 0;
        for (int k = 0; k < TailCycles && !timedOut; k++) begin
            @(negedge clk);
            if (wbEn !== 1'b0) begin
                $display("Fail: wbEn after the last write expected 0 got %h at wbAddr %h",
                         wbEn, wbAddr);
                extra++;
            end
        end
        reportTest("alu and upper", chk[0], err[0]);
        reportTest("loads after stores", chk[1], err[1]);
        reportTest("jump links", chk[2], err[2]);
        reportTest("write order and count", expData.size(),
                   int'(timedOut) + extra + (expData.size() - got));
        $display("tests 5, failed %0d, writes %0d, errors %0d", testsFailed, got, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
source/rv_isa_pkg.sv
source/core_ctrl_pkg.sv
source/ctrlIf.sv
source/control.sv
source/immExtend.sv
source/regFile.sv
source/executeUnit.sv
source/loadStoreUnit.sv
source/cpuTop.sv
testbench/tb_cpuTop.sv

/* run.sh */
#!/usr/bin/env bash
# build the cpuTop testbench with Verilator, run it, and judge the log

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_cpuTop -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^TEST OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
